// File: rtl/i2c_wb_pkg.sv
// shared types and constants for the byte-wide I2C master
// register map follows the usual 8-register layout, address 5 reserved
// prescale counts clk cycles per quarter SCL period
package i2c_wb_pkg;

    typedef logic [2:0]  wb_adr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [6:0]  i2c_addr_t;
    typedef logic [15:0] prescale_t;

    // command fifo word, 10 bits
    typedef struct packed {
        i2c_addr_t addr;
        logic      read;
        logic      write;
        logic      stop;
    } cmd_t;

    // engine status toward the register bank
    typedef struct packed {
        logic busy;
        logic bus_cont;
        logic missed_ack_pulse;
    } engine_status_t;

    // register addresses
    localparam wb_adr_t ADR_STATUS      = 3'd0;
    localparam wb_adr_t ADR_FIFO_STATUS = 3'd1;
    localparam wb_adr_t ADR_CMD_ADDR    = 3'd2;
    localparam wb_adr_t ADR_CMD         = 3'd3;
    localparam wb_adr_t ADR_DATA        = 3'd4;
    localparam wb_adr_t ADR_PRESCALE_LO = 3'd6;
    localparam wb_adr_t ADR_PRESCALE_HI = 3'd7;

    // bit positions in the command register
    localparam int CMD_BIT_READ  = 1;
    localparam int CMD_BIT_WRITE = 2;
    localparam int CMD_BIT_STOP  = 4;

endpackage

// File: rtl/sync_fifo.sv
// show-ahead synchronous fifo, any DEPTH of 2 or more
// head word is valid on pop_data_o whenever empty_o is low
// callers must not push when full nor pop when empty
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    output logic             full_o,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o
);

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;

    assign full_o     = (count == CW'(DEPTH));
    assign empty_o    = (count == '0);
    assign pop_data_o = mem[rd_ptr];

    // storage only, no reset
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap at DEPTH-1 so non power of two depths work
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(push_i) - CW'(pop_i);
        end
    end

    // both sides of the fifo are gated by their owners
    assert property (@(posedge clk) disable iff (rst)
        !(push_i && full_o) && !(pop_i && empty_o))
        else $error("fifo pushed while full or popped while empty");

endmodule

// File: rtl/wb_regs.sv
// Wishbone register bank, 8-bit data, 3-bit address
// ack comes one cycle after strobe, never on two cycles in a row
// pushes to a full fifo are dropped and flagged as overflow
// miss_ack clears on status read, overflows on fifo status read
`timescale 1ns/100ps

module wb_regs #(
    parameter i2c_wb_pkg::prescale_t DEFAULT_PRESCALE = 16'd1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  i2c_wb_pkg::wb_adr_t        wbs_adr_i,
    input  i2c_wb_pkg::byte_t          wbs_dat_i,
    input  logic                       wbs_we_i,
    input  logic                       wbs_stb_i,
    input  logic                       wbs_cyc_i,
    output i2c_wb_pkg::byte_t          wbs_dat_o,
    output logic                       wbs_ack_o,
    output logic                       cmd_push_o,
    output i2c_wb_pkg::cmd_t           cmd_data_o,
    input  logic                       cmd_full_i,
    input  logic                       cmd_empty_i,
    output logic                       wr_push_o,
    output i2c_wb_pkg::byte_t          wr_data_o,
    input  logic                       wr_full_i,
    input  logic                       wr_empty_i,
    output logic                       rd_pop_o,
    input  i2c_wb_pkg::byte_t          rd_data_i,
    input  logic                       rd_full_i,
    input  logic                       rd_empty_i,
    input  i2c_wb_pkg::engine_status_t eng_status_i,
    output i2c_wb_pkg::prescale_t      prescale_o
);

    logic                  access;
    logic                  wr_acc;
    logic                  rd_acc;
    logic                  cmd_wr;
    logic                  data_wr;
    i2c_wb_pkg::i2c_addr_t cmd_addr;
    // stop, write, read from msb down
    logic [2:0]            last_cmd;
    i2c_wb_pkg::byte_t     rd_mux;
    logic                  miss_ack;
    logic                  cmd_ovf;
    logic                  wr_ovf;
    i2c_wb_pkg::prescale_t prescale_o_q;

    // one access per ack, the cycle after an ack is skipped
    assign access = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
    assign wr_acc = access && wbs_we_i;
    assign rd_acc = access && !wbs_we_i;

    // command write with at least one of read/write/stop
    assign cmd_wr = wr_acc && (wbs_adr_i == i2c_wb_pkg::ADR_CMD) &&
                    (wbs_dat_i[i2c_wb_pkg::CMD_BIT_READ] ||
                     wbs_dat_i[i2c_wb_pkg::CMD_BIT_WRITE] ||
                     wbs_dat_i[i2c_wb_pkg::CMD_BIT_STOP]);
    assign data_wr = wr_acc && (wbs_adr_i == i2c_wb_pkg::ADR_DATA);

    assign cmd_push_o = cmd_wr && !cmd_full_i;
    assign cmd_data_o = '{addr:  cmd_addr,
                          read:  wbs_dat_i[i2c_wb_pkg::CMD_BIT_READ],
                          write: wbs_dat_i[i2c_wb_pkg::CMD_BIT_WRITE],
                          stop:  wbs_dat_i[i2c_wb_pkg::CMD_BIT_STOP]};
    assign wr_push_o  = data_wr && !wr_full_i;
    assign wr_data_o  = wbs_dat_i;
    // data read pops the head byte if there is one
    assign rd_pop_o   = rd_acc && (wbs_adr_i == i2c_wb_pkg::ADR_DATA) && !rd_empty_i;
    assign prescale_o = prescale_o_q;

    always_comb begin
        rd_mux = '0;
        case (wbs_adr_i)
            i2c_wb_pkg::ADR_STATUS:
                rd_mux = {4'b0, miss_ack, 1'b0, eng_status_i.bus_cont, eng_status_i.busy};
            i2c_wb_pkg::ADR_FIFO_STATUS:
                rd_mux = {rd_full_i, rd_empty_i, wr_ovf, wr_full_i,
                          wr_empty_i, cmd_ovf, cmd_full_i, cmd_empty_i};
            i2c_wb_pkg::ADR_CMD_ADDR:    rd_mux = {1'b0, cmd_addr};
            // stop, write, read in their command bit slots
            i2c_wb_pkg::ADR_CMD:         rd_mux = {3'b0, last_cmd[2], 1'b0, last_cmd[1:0], 1'b0};
            i2c_wb_pkg::ADR_DATA:        rd_mux = rd_empty_i ? '0 : rd_data_i;
            i2c_wb_pkg::ADR_PRESCALE_LO: rd_mux = prescale_o_q[7:0];
            i2c_wb_pkg::ADR_PRESCALE_HI: rd_mux = prescale_o_q[15:8];
            default:                     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbs_ack_o    <= 1'b0;
            prescale_o_q <= DEFAULT_PRESCALE;
            miss_ack     <= 1'b0;
            cmd_ovf      <= 1'b0;
            wr_ovf       <= 1'b0;
        end else begin
            wbs_ack_o <= access;
            // a miss in the same cycle as the clearing read stays visible
            if (rd_acc && wbs_adr_i == i2c_wb_pkg::ADR_STATUS) begin
                miss_ack <= eng_status_i.missed_ack_pulse;
            end else begin
                miss_ack <= miss_ack || eng_status_i.missed_ack_pulse;
            end
            if (rd_acc && wbs_adr_i == i2c_wb_pkg::ADR_FIFO_STATUS) begin
                cmd_ovf <= 1'b0;
                wr_ovf  <= 1'b0;
            end else begin
                cmd_ovf <= cmd_ovf || (cmd_wr && cmd_full_i);
                wr_ovf  <= wr_ovf || (data_wr && wr_full_i);
            end
            if (wr_acc && wbs_adr_i == i2c_wb_pkg::ADR_PRESCALE_LO) begin
                prescale_o_q[7:0] <= wbs_dat_i;
            end
            if (wr_acc && wbs_adr_i == i2c_wb_pkg::ADR_PRESCALE_HI) begin
                prescale_o_q[15:8] <= wbs_dat_i;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            wbs_dat_o <= rd_mux;
        end
        if (wr_acc && wbs_adr_i == i2c_wb_pkg::ADR_CMD_ADDR) begin
            cmd_addr <= wbs_dat_i[6:0];
        end
        if (cmd_wr) begin
            last_cmd <= {cmd_data_o.stop, cmd_data_o.write, cmd_data_o.read};
        end
    end

    // a held strobe gets every second cycle acknowledged
    assert property (@(posedge clk) disable iff (rst) wbs_ack_o |=> !wbs_ack_o)
        else $error("wishbone ack high on two consecutive cycles");

endmodule

// File: rtl/i2c_byte_engine.sv
// I2C master sequencer, one address byte and one data byte per command
// every bit is four phases of prescale_i clk cycles each
// SCL is never sampled, so targets cannot stretch the clock
// a missed address ack skips the data byte and forces a stop
`timescale 1ns/100ps

module i2c_byte_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  i2c_wb_pkg::prescale_t      prescale_i,
    input  i2c_wb_pkg::cmd_t           cmd_i,
    input  logic                       cmd_empty_i,
    output logic                       cmd_pop_o,
    input  i2c_wb_pkg::byte_t          tx_data_i,
    input  logic                       tx_empty_i,
    output logic                       tx_pop_o,
    output i2c_wb_pkg::byte_t          rx_data_o,
    output logic                       rx_push_o,
    input  logic                       rx_full_i,
    output logic                       scl_o,
    input  logic                       sda_i,
    output logic                       sda_o,
    output i2c_wb_pkg::engine_status_t status_o
);

    typedef enum logic [2:0] {
        IDLE, START, ADDR, ADDR_ACK, DATA, DATA_ACK, STOP
    } state_t;

    state_t                state;
    logic [1:0]            phase;
    i2c_wb_pkg::prescale_t presc_cnt;
    logic                  tick;
    logic                  hold;
    logic                  bus_held;
    logic                  missed_ack;
    i2c_wb_pkg::cmd_t      cur;
    i2c_wb_pkg::byte_t     shift;
    logic [2:0]            bit_cnt;
    logic                  nack;

    assign tick = (presc_cnt == '0);

    // phase 3 waits here with SCL low, for tx data or rx room
    assign hold = (state == ADDR_ACK && phase == 2'd3 && !nack && cur.write && tx_empty_i) ||
                  (state == DATA_ACK && phase == 2'd3 && cur.read && rx_full_i);

    assign cmd_pop_o = tick && state == IDLE && !cmd_empty_i;
    assign tx_pop_o  = tick && state == ADDR_ACK && phase == 2'd3 && !nack &&
                       cur.write && !tx_empty_i;
    assign rx_push_o = tick && state == DATA_ACK && phase == 2'd3 && cur.read && !rx_full_i;
    assign rx_data_o = shift;

    // a queued command counts as busy so polling cannot race the engine
    assign status_o = '{busy:             (state != IDLE) || !cmd_empty_i,
                        bus_cont:         bus_held,
                        missed_ack_pulse: missed_ack};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            phase      <= 2'd0;
            presc_cnt  <= '0;
            scl_o      <= 1'b1;
            sda_o      <= 1'b1;
            bus_held   <= 1'b0;
            missed_ack <= 1'b0;
        end else begin
            missed_ack <= 1'b0;
            presc_cnt  <= tick ? prescale_i - 1'b1 : presc_cnt - 1'b1;
            if (tick) begin
                if (state != IDLE && !hold) begin
                    phase <= phase + 1'b1;
                end
                // SCL rises in phase 1, falls in phase 3 except at stop
                if (state != IDLE && phase == 2'd1) begin
                    scl_o <= 1'b1;
                end
                if (state != IDLE && state != STOP && phase == 2'd3) begin
                    scl_o <= 1'b0;
                end
                case (state)
                    IDLE: begin
                        if (!cmd_empty_i) begin
                            // read with write set is dropped here
                            if (cmd_i.read ^ cmd_i.write) begin
                                state <= START;
                            end else if (!cmd_i.write && cmd_i.stop && bus_held) begin
                                state <= STOP;
                            end
                        end
                    end
                    START: begin
                        // release sda first so a repeated start works too
                        if (phase == 2'd0) sda_o <= 1'b1;
                        if (phase == 2'd2) sda_o <= 1'b0;
                        if (phase == 2'd3) begin
                            bus_held <= 1'b1;
                            state    <= ADDR;
                        end
                    end
                    ADDR: begin
                        if (phase == 2'd0) sda_o <= shift[7];
                        if (phase == 2'd3 && bit_cnt == 3'd0) state <= ADDR_ACK;
                    end
                    ADDR_ACK: begin
                        if (phase == 2'd0) sda_o <= 1'b1;
                        if (phase == 2'd3) begin
                            if (nack) begin
                                missed_ack <= 1'b1;
                                state      <= STOP;
                            end else if (!hold) begin
                                state <= DATA;
                            end
                        end
                    end
                    DATA: begin
                        if (phase == 2'd0) sda_o <= cur.write ? shift[7] : 1'b1;
                        if (phase == 2'd3 && bit_cnt == 3'd0) state <= DATA_ACK;
                    end
                    DATA_ACK: begin
                        // on reads nack the last byte, ack otherwise
                        if (phase == 2'd0) sda_o <= cur.read ? cur.stop : 1'b1;
                        if (phase == 2'd3 && !hold) state <= cur.stop ? STOP : IDLE;
                    end
                    STOP: begin
                        if (phase == 2'd0) sda_o <= 1'b0;
                        if (phase == 2'd2) sda_o <= 1'b1;
                        if (phase == 2'd3) begin
                            bus_held <= 1'b0;
                            state    <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // byte datapath
    always_ff @(posedge clk) begin
        if (cmd_pop_o) begin
            cur <= cmd_i;
        end
        if (tick) begin
            if (state == START && phase == 2'd3) begin
                shift   <= {cur.addr, cur.read};
                bit_cnt <= 3'd7;
            end
            // sample mid high; on writes this just moves the next bit up
            if ((state == ADDR || state == DATA) && phase == 2'd2) begin
                shift <= {shift[6:0], sda_i};
            end
            // wraps back to 7 after the last bit
            if ((state == ADDR || state == DATA) && phase == 2'd3) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
            if (state == ADDR_ACK && phase == 2'd2) begin
                nack <= sda_i;
            end
        end
        if (tx_pop_o) begin
            shift <= tx_data_i;
        end
    end

    // data line moves only with SCL low, start and stop excepted
    assert property (@(posedge clk) disable iff (rst)
        $changed(sda_o) |-> !scl_o || state inside {START, STOP})
        else $error("sda changed while scl high outside start/stop");

endmodule

// File: rtl/i2c_master_wb.sv
// I2C master with Wishbone register port, 8-bit data
// pins are open-drain: a low _o pulls the line, a high _o releases it
// i2c_scl_i is not used, there is no clock stretching
`timescale 1ns/100ps

module i2c_master_wb #(
    parameter i2c_wb_pkg::prescale_t DEFAULT_PRESCALE = 16'd1,
    parameter int                    CMD_FIFO_DEPTH   = 4,
    parameter int                    DATA_FIFO_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  i2c_wb_pkg::wb_adr_t wbs_adr_i,
    input  i2c_wb_pkg::byte_t   wbs_dat_i,
    output i2c_wb_pkg::byte_t   wbs_dat_o,
    input  logic                wbs_we_i,
    input  logic                wbs_stb_i,
    output logic                wbs_ack_o,
    input  logic                wbs_cyc_i,
    input  logic                i2c_scl_i,
    output logic                i2c_scl_o,
    input  logic                i2c_sda_i,
    output logic                i2c_sda_o
);

    localparam int CMD_W  = $bits(i2c_wb_pkg::cmd_t);
    localparam int BYTE_W = $bits(i2c_wb_pkg::byte_t);

    // command path
    logic                       cmd_push, cmd_pop, cmd_full, cmd_empty;
    i2c_wb_pkg::cmd_t           cmd_wdata, cmd_head;
    // host to target bytes
    logic                       wr_push, wr_pop, wr_full, wr_empty;
    i2c_wb_pkg::byte_t          wr_wdata, wr_head;
    // target to host bytes
    logic                       rd_push, rd_pop, rd_full, rd_empty;
    i2c_wb_pkg::byte_t          rd_wdata, rd_head;
    i2c_wb_pkg::engine_status_t eng_status;
    i2c_wb_pkg::prescale_t      prescale;

    wb_regs #(.DEFAULT_PRESCALE(DEFAULT_PRESCALE)) regs_i (
        .clk, .rst, .wbs_adr_i, .wbs_dat_i, .wbs_we_i, .wbs_stb_i, .wbs_cyc_i,
        .wbs_dat_o, .wbs_ack_o,
        .cmd_push_o(cmd_push), .cmd_data_o(cmd_wdata),
        .cmd_full_i(cmd_full), .cmd_empty_i(cmd_empty),
        .wr_push_o(wr_push), .wr_data_o(wr_wdata),
        .wr_full_i(wr_full), .wr_empty_i(wr_empty),
        .rd_pop_o(rd_pop), .rd_data_i(rd_head),
        .rd_full_i(rd_full), .rd_empty_i(rd_empty),
        .eng_status_i(eng_status), .prescale_o(prescale)
    );

    sync_fifo #(.WIDTH(CMD_W), .DEPTH(CMD_FIFO_DEPTH)) cmd_fifo (
        .clk, .rst, .push_i(cmd_push), .push_data_i(cmd_wdata), .full_o(cmd_full),
        .pop_i(cmd_pop), .pop_data_o(cmd_head), .empty_o(cmd_empty)
    );

    sync_fifo #(.WIDTH(BYTE_W), .DEPTH(DATA_FIFO_DEPTH)) write_fifo (
        .clk, .rst, .push_i(wr_push), .push_data_i(wr_wdata), .full_o(wr_full),
        .pop_i(wr_pop), .pop_data_o(wr_head), .empty_o(wr_empty)
    );

    sync_fifo #(.WIDTH(BYTE_W), .DEPTH(DATA_FIFO_DEPTH)) read_fifo (
        .clk, .rst, .push_i(rd_push), .push_data_i(rd_wdata), .full_o(rd_full),
        .pop_i(rd_pop), .pop_data_o(rd_head), .empty_o(rd_empty)
    );

    i2c_byte_engine engine_i (
        .clk, .rst, .prescale_i(prescale),
        .cmd_i(cmd_head), .cmd_empty_i(cmd_empty), .cmd_pop_o(cmd_pop),
        .tx_data_i(wr_head), .tx_empty_i(wr_empty), .tx_pop_o(wr_pop),
        .rx_data_o(rd_wdata), .rx_push_o(rd_push), .rx_full_i(rd_full),
        .scl_o(i2c_scl_o), .sda_i(i2c_sda_i), .sda_o(i2c_sda_o),
        .status_o(eng_status)
    );

endmodule

// File: tests/i2c_slave_model.sv
// behavioral I2C target for simulation only
// drives sda low for ack and read bits, never touches scl
// answers only OWN_ADDR, records every address it sees
// one data byte per transfer, the master's ack after a read ends it
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] OWN_ADDR  = 7'h50,
    parameter logic [7:0] READ_BYTE = 8'hA5
) (
    input  logic       scl_i,
    input  logic       sda_i,
    output logic       sda_o,
    output logic [6:0] last_addr_o,
    output logic       last_rw_o,
    output logic [7:0] last_data_o,
    output logic       rd_nack_o,
    output int         wr_count_o
);

    typedef enum {
        S_IDLE, S_ADDR, S_ADDR_ACK, S_WRITE, S_WRITE_ACK, S_READ, S_READ_ACK
    } slave_state_t;

    slave_state_t state;
    logic [7:0]   sr;
    int           cnt;

    initial begin
        state       = S_IDLE;
        sr          = '0;
        cnt         = 0;
        sda_o       = 1'b1;
        last_addr_o = '0;
        last_rw_o   = 1'b0;
        last_data_o = '0;
        rd_nack_o   = 1'b0;
        wr_count_o  = 0;
    end

    // start or repeated start
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            state = S_ADDR;
            cnt   = 0;
            sda_o = 1'b1;
        end
    end

    // stop
    always @(posedge sda_i) begin
        if (scl_i === 1'b1) begin
            state = S_IDLE;
            sda_o = 1'b1;
        end
    end

    // sample on rising scl
    always @(posedge scl_i) begin
        case (state)
            S_ADDR, S_WRITE: begin
                sr  = {sr[6:0], sda_i};
                cnt = cnt + 1;
            end
            S_READ:     cnt = cnt + 1;
            // high here means the master did not ack the byte
            S_READ_ACK: rd_nack_o = sda_i;
            default:    ;
        endcase
    end

    // change sda only after scl fell
    always @(negedge scl_i) begin
        case (state)
            S_ADDR: begin
                if (cnt == 8) begin
                    last_addr_o = sr[7:1];
                    last_rw_o   = sr[0];
                    if (sr[7:1] == OWN_ADDR) begin
                        sda_o = 1'b0;
                        state = S_ADDR_ACK;
                    end else begin
                        state = S_IDLE;
                    end
                end
            end
            S_ADDR_ACK: begin
                cnt = 0;
                if (last_rw_o) begin
                    sda_o = READ_BYTE[7];
                    state = S_READ;
                end else begin
                    sda_o = 1'b1;
                    state = S_WRITE;
                end
            end
            S_WRITE: begin
                if (cnt == 8) begin
                    last_data_o = sr;
                    wr_count_o  = wr_count_o + 1;
                    sda_o       = 1'b0;
                    state       = S_WRITE_ACK;
                end
            end
            S_WRITE_ACK: begin
                sda_o = 1'b1;
                state = S_IDLE;
            end
            S_READ: begin
                if (cnt == 8) begin
                    sda_o = 1'b1;
                    state = S_READ_ACK;
                end else begin
                    sda_o = READ_BYTE[7 - cnt];
                end
            end
            S_READ_ACK: state = S_IDLE;
            default:    ;
        endcase
    end

endmodule

// File: tests/tb_i2c_master_wb.sv
// directed testbench for the Wishbone I2C master
// prescale 4, all FIFOs 4 deep, slave model at address 0x50
// tests run in order and share FIFO contents, one byte is left queued by the missed ack test
`timescale 1ns/100ps

module tb_i2c_master_wb;

    localparam logic [15:0] PRESCALE    = 16'd4;
    localparam int          DEPTH       = 4;
    localparam int          CLK_NS      = 20;
    // 20 bits per transfer, 4 phases per bit
    localparam int          TRANSFER_NS = 20 * 4 * PRESCALE * CLK_NS;
    localparam int          WATCHDOG_NS = 5 * TRANSFER_NS + 20000;
    localparam int          ACK_LIMIT   = 16;
    localparam int          POLL_LIMIT  = 400;

    // status and fifo status bits, reference layout
    localparam logic [7:0] ST_BUSY      = 8'h01;
    localparam logic [7:0] ST_BUS_CONT  = 8'h02;
    localparam logic [7:0] ST_MISS_ACK  = 8'h08;
    localparam logic [7:0] FS_CMD_EMPTY = 8'h01;
    localparam logic [7:0] FS_WR_EMPTY  = 8'h08;
    localparam logic [7:0] FS_WR_FULL   = 8'h10;
    localparam logic [7:0] FS_WR_OVF    = 8'h20;
    localparam logic [7:0] FS_RD_EMPTY  = 8'h40;

    localparam logic [7:0] CMD_WRITE_STOP = (8'd1 << i2c_wb_pkg::CMD_BIT_WRITE) |
                                            (8'd1 << i2c_wb_pkg::CMD_BIT_STOP);
    localparam logic [7:0] CMD_READ_STOP  = (8'd1 << i2c_wb_pkg::CMD_BIT_READ) |
                                            (8'd1 << i2c_wb_pkg::CMD_BIT_STOP);

    logic                clk = 1'b0;
    logic                rst;
    i2c_wb_pkg::wb_adr_t wbs_adr;
    i2c_wb_pkg::byte_t   wbs_dat_w;
    i2c_wb_pkg::byte_t   wbs_dat_r;
    logic                wbs_we;
    logic                wbs_stb;
    logic                wbs_cyc;
    logic                wbs_ack;
    logic                dut_scl;
    logic                dut_sda;
    logic                slave_sda;
    logic                scl_line;
    logic                sda_line;
    logic [6:0]          slave_addr;
    logic                slave_rw;
    logic [7:0]          slave_data;
    logic                slave_nack;
    int                  slave_writes;
    int                  checks = 0;
    int                  errors = 0;

    // open-drain bus, wired AND of both sides
    assign scl_line = dut_scl;
    assign sda_line = dut_sda & slave_sda;

    always #(CLK_NS / 2) clk = ~clk;

    i2c_master_wb #(
        .DEFAULT_PRESCALE(PRESCALE),
        .CMD_FIFO_DEPTH(DEPTH),
        .DATA_FIFO_DEPTH(DEPTH)
    ) dut_i (
        .clk(clk), .rst(rst),
        .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w), .wbs_dat_o(wbs_dat_r),
        .wbs_we_i(wbs_we), .wbs_stb_i(wbs_stb), .wbs_ack_o(wbs_ack), .wbs_cyc_i(wbs_cyc),
        .i2c_scl_i(scl_line), .i2c_scl_o(dut_scl),
        .i2c_sda_i(sda_line), .i2c_sda_o(dut_sda)
    );

    i2c_slave_model #(.OWN_ADDR(7'h50), .READ_BYTE(8'hA5)) slave_i (
        .scl_i(scl_line), .sda_i(sda_line), .sda_o(slave_sda),
        .last_addr_o(slave_addr), .last_rw_o(slave_rw), .last_data_o(slave_data),
        .rd_nack_o(slave_nack), .wr_count_o(slave_writes)
    );

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // one bus cycle, inputs move 2 ns after the edge, ack sampled there too
    task automatic wb_access(input i2c_wb_pkg::wb_adr_t adr, input logic we,
                             input i2c_wb_pkg::byte_t wdata,
                             output i2c_wb_pkg::byte_t rdata);
        int waited;
        @(posedge clk);
        #2;
        wbs_adr   = adr;
        wbs_dat_w = wdata;
        wbs_we    = we;
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        waited    = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wbs_ack && waited < ACK_LIMIT);
        assert (wbs_ack === 1'b1) else begin
            errors++;
            $display("no Wishbone ack within %0d cycles at address %0d", ACK_LIMIT, adr);
        end
        rdata   = wbs_dat_r;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic wb_write(input i2c_wb_pkg::wb_adr_t adr, input i2c_wb_pkg::byte_t data);
        i2c_wb_pkg::byte_t discard;
        wb_access(adr, 1'b1, data, discard);
    endtask

    task automatic wb_read(input i2c_wb_pkg::wb_adr_t adr, output i2c_wb_pkg::byte_t data);
        wb_access(adr, 1'b0, 8'h00, data);
    endtask

    // poll status until idle, counting reads that caught the sticky miss flag
    task automatic wait_idle(output int miss_reads, output i2c_wb_pkg::byte_t last_status);
        int                polls;
        i2c_wb_pkg::byte_t st;
        miss_reads = 0;
        polls      = 0;
        do begin
            wb_read(i2c_wb_pkg::ADR_STATUS, st);
            if (st & ST_MISS_ACK) begin
                miss_reads++;
            end
            polls++;
        end while ((st & ST_BUSY) && polls < POLL_LIMIT);
        last_status = st;
        assert (!(st & ST_BUSY)) else begin
            errors++;
            $display("engine still busy after %0d status reads", polls);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - errs_before);
        end
    endtask

    task automatic reset_values();
        int                e0;
        i2c_wb_pkg::byte_t d;
        e0 = errors;
        wb_read(i2c_wb_pkg::ADR_FIFO_STATUS, d);
        check_value("fifo_status", d, FS_CMD_EMPTY | FS_WR_EMPTY | FS_RD_EMPTY);
        wb_read(i2c_wb_pkg::ADR_STATUS, d);
        check_value("status", d, 8'h00);
        wb_read(i2c_wb_pkg::ADR_PRESCALE_LO, d);
        check_value("prescale_lo", d, PRESCALE[7:0]);
        wb_read(i2c_wb_pkg::ADR_PRESCALE_HI, d);
        check_value("prescale_hi", d, PRESCALE[15:8]);
        wb_write(i2c_wb_pkg::ADR_PRESCALE_LO, 8'h5A);
        wb_write(i2c_wb_pkg::ADR_PRESCALE_HI, 8'h01);
        wb_read(i2c_wb_pkg::ADR_PRESCALE_LO, d);
        check_value("prescale_lo", d, 8'h5A);
        wb_read(i2c_wb_pkg::ADR_PRESCALE_HI, d);
        check_value("prescale_hi", d, 8'h01);
        // back to the default so bus timing stays known
        wb_write(i2c_wb_pkg::ADR_PRESCALE_LO, PRESCALE[7:0]);
        wb_write(i2c_wb_pkg::ADR_PRESCALE_HI, PRESCALE[15:8]);
        wb_write(i2c_wb_pkg::ADR_CMD_ADDR, 8'h2B);
        wb_read(i2c_wb_pkg::ADR_CMD_ADDR, d);
        check_value("cmd_addr", d, 8'h2B);
        report_test("reset_values", e0);
    endtask

    task automatic write_transfer();
        int                e0;
        int                writes0;
        int                miss_reads;
        i2c_wb_pkg::byte_t st;
        i2c_wb_pkg::byte_t d;
        e0      = errors;
        writes0 = slave_writes;
        wb_write(i2c_wb_pkg::ADR_DATA, 8'h3C);
        wb_write(i2c_wb_pkg::ADR_CMD_ADDR, 8'h50);
        wb_write(i2c_wb_pkg::ADR_CMD, CMD_WRITE_STOP);
        wait_idle(miss_reads, st);
        check_value("slave_addr", slave_addr, 7'h50);
        check_value("slave_rw", slave_rw, 1'b0);
        check_value("slave_data", slave_data, 8'h3C);
        check_value("slave_writes", slave_writes, writes0 + 1);
        check_value("bus_cont", st & ST_BUS_CONT, 8'h00);
        check_value("miss_ack_reads", miss_reads, 0);
        // last command bits read back in their own slots
        wb_read(i2c_wb_pkg::ADR_CMD, d);
        check_value("cmd", d, CMD_WRITE_STOP);
        report_test("write_transfer", e0);
    endtask

    task automatic read_transfer();
        int                e0;
        int                miss_reads;
        i2c_wb_pkg::byte_t st;
        i2c_wb_pkg::byte_t d;
        e0 = errors;
        wb_write(i2c_wb_pkg::ADR_CMD_ADDR, 8'h50);
        wb_write(i2c_wb_pkg::ADR_CMD, CMD_READ_STOP);
        wait_idle(miss_reads, st);
        check_value("slave_rw", slave_rw, 1'b1);
        // stop was set, so the master must nack the byte
        check_value("master_nack", slave_nack, 1'b1);
        wb_read(i2c_wb_pkg::ADR_FIFO_STATUS, d);
        check_value("fifo_status", d, FS_CMD_EMPTY | FS_WR_EMPTY);
        wb_read(i2c_wb_pkg::ADR_DATA, d);
        check_value("rd_data", d, 8'hA5);
        wb_read(i2c_wb_pkg::ADR_FIFO_STATUS, d);
        check_value("fifo_status", d, FS_CMD_EMPTY | FS_WR_EMPTY | FS_RD_EMPTY);
        wb_read(i2c_wb_pkg::ADR_DATA, d);
        check_value("rd_data", d, 8'h00);
        report_test("read_transfer", e0);
    endtask

    task automatic missed_ack();
        int                e0;
        int                writes0;
        int                miss_reads;
        i2c_wb_pkg::byte_t st;
        i2c_wb_pkg::byte_t d;
        e0      = errors;
        writes0 = slave_writes;
        wb_write(i2c_wb_pkg::ADR_DATA, 8'h77);
        wb_write(i2c_wb_pkg::ADR_CMD_ADDR, 8'h21);
        wb_write(i2c_wb_pkg::ADR_CMD, CMD_WRITE_STOP);
        wait_idle(miss_reads, st);
        // sticky flag seen by exactly one status read, cleared after
        check_value("miss_ack_reads", miss_reads, 1);
        wb_read(i2c_wb_pkg::ADR_STATUS, d);
        check_value("status", d, 8'h00);
        check_value("slave_addr", slave_addr, 7'h21);
        check_value("slave_writes", slave_writes, writes0);
        wb_read(i2c_wb_pkg::ADR_FIFO_STATUS, d);
        check_value("fifo_status", d, FS_CMD_EMPTY | FS_RD_EMPTY);
        report_test("missed_ack", e0);
    endtask

    task automatic fifo_overflow();
        int                e0;
        i2c_wb_pkg::byte_t d;
        e0 = errors;
        for (int i = 0; i <= DEPTH; i++) begin
            wb_write(i2c_wb_pkg::ADR_DATA, 8'h10 + i);
        end
        wb_read(i2c_wb_pkg::ADR_FIFO_STATUS, d);
        check_value("fifo_status", d, FS_CMD_EMPTY | FS_WR_FULL | FS_WR_OVF | FS_RD_EMPTY);
        wb_read(i2c_wb_pkg::ADR_FIFO_STATUS, d);
        check_value("fifo_status", d, FS_CMD_EMPTY | FS_WR_FULL | FS_RD_EMPTY);
        report_test("fifo_overflow", e0);
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        wbs_adr   = '0;
        wbs_dat_w = '0;
        wbs_we    = 1'b0;
        wbs_stb   = 1'b0;
        wbs_cyc   = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_values();
        write_transfer();
        read_transfer();
        missed_ack();
        fifo_overflow();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/i2c_wb_pkg.sv
rtl/sync_fifo.sv
rtl/wb_regs.sv
rtl/i2c_byte_engine.sv
rtl/i2c_master_wb.sv
tests/i2c_slave_model.sv
tests/tb_i2c_master_wb.sv
